// File: verilog.f
+incdir+include
hw/execPkg.sv
hw/execDecode.sv
hw/execAlu.sv
hw/execResolve.sv
hw/execStage.sv
tests/execStage_sva.sv
tests/execStageTb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execStageTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(FILELIST) $(wildcard hw/*.sv tests/*.sv include/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -qx "Finished with no errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/execStageTb.sv
/*
   Testbench of the execute stage
   Random instructions, reference model, typed compare tasks
*/
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module execStageTb;

   localparam int drainLimit = 20;

   // Kept opcodes: ALU ops 0..4, data ops 5..11, branches and jumps 12..17
   localparam execPkg::opcode_t opTable [18] = '{
      5'b11011, 5'b01000, 5'b01001, 5'b01010, 5'b01011,
      5'b11100, 5'b11101, 5'b11110, 5'b11111, 5'b11001, 5'b11000, 5'b10010,
      5'b01100, 5'b01101, 5'b01110, 5'b01111, 5'b00100, 5'b00101};

   logic             clk = 1'b0;
   logic             rst;
   logic             instValid;
   execPkg::exIn_t   exIn;
   execPkg::fwdSel_t fwdA;
   execPkg::fwdSel_t fwdB;
   execPkg::word_t   wbData;
   logic             resultValid;
   execPkg::exOut_t  exOut;

   execPkg::exOut_t  expQ[$];
   execPkg::exOut_t  heldOut;
   execPkg::word_t   lastResult;
   logic             validDue;
   int               checks = 0;
   int               errors = 0;
   int               tests = 0;
   int unsigned      seed;

   execStage i_execStage (
      .clk         (clk),
      .rst         (rst),
      .instValid   (instValid),
      .exIn        (exIn),
      .fwdA        (fwdA),
      .fwdB        (fwdB),
      .wbData      (wbData),
      .resultValid (resultValid),
      .exOut       (exOut)
   );

   always #10 clk = ~clk;

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic checkWord(input string name, input execPkg::word_t got,
                            input execPkg::word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic checkOut(input execPkg::exOut_t got, input execPkg::exOut_t exp);
      checkWord("exOut.instruction", got.instruction, exp.instruction);
      checkWord("exOut.result", got.result, exp.result);
      checkWord("exOut.newPC", got.newPC, exp.newPC);
      checkBit("exOut.pcSrc", got.pcSrc, exp.pcSrc);
      checkWord("exOut.storeData", got.storeData, exp.storeData);
      checkBit("exOut.regWrt", got.regWrt, exp.regWrt);
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   // One instruction from the instruction set rules, on forwarded operands
   function automatic execPkg::exOut_t predict(input execPkg::exIn_t in,
                                               input execPkg::fwdSel_t selA,
                                               input execPkg::fwdSel_t selB,
                                               input execPkg::word_t wb,
                                               input execPkg::word_t last);
      execPkg::exOut_t       o;
      execPkg::word_t        a;
      execPkg::word_t        b;
      execPkg::word_t        s5;
      execPkg::word_t        z5;
      execPkg::word_t        s8;
      execPkg::word_t        s11;
      logic [`EXEC_WORD_W:0] wideSum;
      logic                  taken;
      a = (selA == 2'd1) ? wb : (selA == 2'd2) ? last : in.regA;
      b = (selB == 2'd1) ? wb : (selB == 2'd2) ? last : in.regB;
      s5 = {{11{in.instruction[4]}}, in.instruction[4:0]};
      z5 = {11'b0, in.instruction[4:0]};
      s8 = {{8{in.instruction[7]}}, in.instruction[7:0]};
      s11 = {{5{in.instruction[10]}}, in.instruction[10:0]};
      wideSum = {1'b0, a} + {1'b0, b};
      o = '0;
      o.instruction = in.instruction;
      o.storeData = b;
      o.regWrt = in.regWrt;
      o.newPC = in.incrPC;
      // Branches and jumps see B as zero, so the ALU word is A
      o.result = a;
      taken = 1'b0;
      case (in.instruction[15:11])
         5'b11011: begin
            case (in.instruction[1:0])
               2'b00: o.result = a + b;
               2'b01: o.result = b - a;
               2'b10: o.result = a ^ b;
               default: o.result = a & ~b;
            endcase
         end
         5'b01000: o.result = a + s5;
         5'b01001: o.result = s5 - a;
         5'b01010: o.result = a ^ z5;
         5'b01011: o.result = a & ~z5;
         5'b11100: o.result = execPkg::word_t'(a == b);
         5'b11101: o.result = execPkg::word_t'($signed(a) < $signed(b));
         5'b11110: o.result = execPkg::word_t'($signed(a) <= $signed(b));
         5'b11111: o.result = execPkg::word_t'(wideSum[`EXEC_WORD_W]);
         5'b11001: begin
            for (int k = 0; k < `EXEC_WORD_W; k++) begin
               o.result[k] = a[`EXEC_WORD_W-1-k];
            end
         end
         5'b11000: o.result = s8;
         5'b10010: o.result = {a[7:0], in.instruction[7:0]};
         5'b01100: taken = (a == '0);
         5'b01101: taken = (a != '0);
         5'b01110: taken = a[`EXEC_WORD_W-1];
         5'b01111: taken = ~a[`EXEC_WORD_W-1];
         5'b00100: begin
            taken = 1'b1;
            o.newPC = in.incrPC + s11;
         end
         5'b00101: begin
            taken = 1'b1;
            o.newPC = a + s8;
         end
         default: o.result = a + b;
      endcase
      // Conditional branches are PC-relative on the 8-bit offset
      if (taken && in.instruction[15:13] == 3'b011) begin
         o.newPC = in.incrPC + s8;
      end
      o.pcSrc = taken;
      return o;
   endfunction

   // Random word, often a sign or overflow corner
   function automatic execPkg::word_t pickOperand();
      logic [31:0] r;
      r = $urandom;
      case (r[18:16])
         3'd0: return 16'h8000;
         3'd1: return 16'h7fff;
         3'd2: return 16'hffff;
         3'd3: return 16'h0000;
         default: return r[15:0];
      endcase
   endfunction

   ////////////////////
   // Stimulus and checking
   ////////////////////

   // A strobe seen on this edge owes a result one cycle later
   always @(posedge clk) begin
      validDue <= (instValid === 1'b1) && (rst === 1'b0);
   end

   // Results are checked mid-cycle where the register outputs are stable
   always @(negedge clk) begin
      if (rst === 1'b0) begin
         checkBit("resultValid", resultValid, validDue);
         if (validDue === 1'b1) begin
            if (expQ.size() == 0) begin
               errors++;
               $display("a result was due at time %0t with no instruction in flight", $time);
            end else begin
               heldOut = expQ.pop_front();
            end
         end
         // Without a strobe the register keeps the last result
         checkOut(exOut, heldOut);
      end
   end

   task automatic reportTest(input string name, input int startChecks, input int startErrors);
      tests++;
      $display("test %s done: %0d checks, %0d errors", name, checks - startChecks,
               errors - startErrors);
   endtask

   task automatic drainResults();
      int waited;
      waited = 0;
      while (expQ.size() != 0 && waited < drainLimit) begin
         @(posedge clk);
         waited++;
      end
      if (expQ.size() != 0) begin
         errors++;
         $display("timeout: %0d results never came out on resultValid", expQ.size());
         expQ.delete();
      end
   endtask

   // Back-to-back strobes drawn from opTable[lo..hi]
   task automatic runTest(input string name, input int lo, input int hi, input int count,
                          input bit useFwd);
      int               startChecks;
      int               startErrors;
      int               n;
      int               idx;
      logic [31:0]      rnd;
      execPkg::exIn_t   in;
      execPkg::fwdSel_t selA;
      execPkg::fwdSel_t selB;
      execPkg::word_t   wb;
      execPkg::exOut_t  exp;
      startChecks = checks;
      startErrors = errors;
      for (n = 0; n < count; n++) begin
         @(posedge clk);
         #1;
         rnd = $urandom % (hi - lo + 1);
         idx = lo + int'(rnd);
         rnd = $urandom;
         in.instruction = {opTable[idx], rnd[10:0]};
         in.regWrt = rnd[16];
         in.incrPC = pickOperand();
         in.regA = pickOperand();
         in.regB = pickOperand();
         wb = pickOperand();
         selA = 2'd0;
         selB = 2'd0;
         if (useFwd) begin
            rnd = $urandom % 3;
            selA = rnd[1:0];
            rnd = $urandom % 3;
            selB = rnd[1:0];
         end
         instValid = 1'b1;
         exIn = in;
         fwdA = selA;
         fwdB = selB;
         wbData = wb;
         exp = predict(in, selA, selB, wb, lastResult);
         expQ.push_back(exp);
         lastResult = exp.result;
      end
      @(posedge clk);
      #1;
      instValid = 1'b0;
      drainResults();
      reportTest(name, startChecks, startErrors);
   endtask

   initial begin
      seed = $urandom(86755);
      rst = 1'b1;
      instValid = 1'b0;
      exIn = '0;
      fwdA = 2'd0;
      fwdB = 2'd0;
      wbData = '0;
      lastResult = '0;
      heldOut = '0;
      validDue = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      // Cleared after reset, then held with no strobe
      checkBit("resultValid", resultValid, 1'b0);
      checkOut(exOut, '0);
      repeat (3) @(posedge clk);
      #1;
      checkBit("resultValid", resultValid, 1'b0);
      checkOut(exOut, '0);
      reportTest("reset", 0, 0);

      runTest("alu", 0, 4, 200, 1'b0);
      runTest("compare", 5, 11, 200, 1'b0);
      runTest("branch", 12, 17, 200, 1'b0);
      runTest("forward", 0, 17, 300, 1'b1);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/execStage_sva.sv
/*
   Assertions on the execute stage
   Reset state, one-cycle valid latency, PC source before first result
*/
`timescale 1ns/1ps
`default_nettype none

module execStage_sva (
   input wire                  clk,
   input wire                  rst,
   input wire                  instValid,
   input wire                  resultValid,
   input wire execPkg::exOut_t exOut
);

   // Set once the first result has come out
   logic seenValid;

   always_ff @(posedge clk) begin
      if (rst) begin
         seenValid <= 1'b0;
      end else if (resultValid) begin
         seenValid <= 1'b1;
      end
   end

   ////////////////////
   // Properties
   ////////////////////

   resetLow: assert property (@(posedge clk) rst |=> !resultValid)
      else $error("resultValid high after a reset cycle");

   validFollows: assert property (@(posedge clk) disable iff (rst) instValid |=> resultValid)
      else $error("resultValid missing one cycle after instValid");

   validOnlyAfterStrobe: assert property (@(posedge clk) disable iff (rst)
      !instValid |=> !resultValid)
      else $error("resultValid high with no instValid the cycle before");

   // No redirect before any instruction has gone through
   pcSrcQuiet: assert property (@(posedge clk) disable iff (rst)
      (!seenValid && !resultValid) |-> !exOut.pcSrc)
      else $error("pcSrc high before any result");

endmodule

bind execStage execStage_sva i_execStage_sva (
   .clk         (clk),
   .rst         (rst),
   .instValid   (instValid),
   .resultValid (resultValid),
   .exOut       (exOut)
);

`default_nettype wire

// File: hw/execStage.sv
/*
   Execute stage top level
   Operand forwarding, operand B select, sub-blocks, EX/MEM register
*/
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module execStage (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   instValid,
   input  wire execPkg::exIn_t   exIn,
   input  wire execPkg::fwdSel_t fwdA,
   input  wire execPkg::fwdSel_t fwdB,
   input  wire execPkg::word_t   wbData,
   output logic                  resultValid,
   output execPkg::exOut_t       exOut
);

   execPkg::ctrl_t     ctrl;
   execPkg::aluFlags_t flags;
   execPkg::exOut_t    nextOut;
   execPkg::word_t     opA;
   execPkg::word_t     opB;
   execPkg::word_t     aluB;
   execPkg::word_t     imm5;
   execPkg::word_t     imm8;
   execPkg::word_t     aluOut;
   logic               carryOut;
   logic               ext5;
   logic               ext8;

   // Register file, write-back or our own last result
   function automatic execPkg::word_t fwdMux(input execPkg::fwdSel_t sel,
                                             input execPkg::word_t regVal,
                                             input execPkg::word_t wbVal,
                                             input execPkg::word_t exVal);
      case (sel)
         execPkg::fwdWb: return wbVal;
         execPkg::fwdEx: return exVal;
         default:        return regVal;
      endcase
   endfunction

   assign opA = fwdMux(fwdA, exIn.regA, wbData, exOut.result);
   assign opB = fwdMux(fwdB, exIn.regB, wbData, exOut.result);

   ////////////////////
   // Operand B
   ////////////////////

   execDecode i_execDecode (
      .instruction (exIn.instruction),
      .ctrl        (ctrl)
   );

   // XORI and ANDNI zero-extend
   assign ext5 = ~ctrl.zeroExt & exIn.instruction[`EXEC_IMM5_W-1];
   assign ext8 = ~ctrl.zeroExt & exIn.instruction[`EXEC_IMM8_W-1];
   assign imm5 = {{(`EXEC_WORD_W-`EXEC_IMM5_W){ext5}}, exIn.instruction[`EXEC_IMM5_W-1:0]};
   assign imm8 = {{(`EXEC_WORD_W-`EXEC_IMM8_W){ext8}}, exIn.instruction[`EXEC_IMM8_W-1:0]};

   always_comb begin
      case (ctrl.bSel)
         execPkg::bSelImm5: aluB = imm5;
         execPkg::bSelImm8: aluB = imm8;
         execPkg::bSelSlbi: aluB = {opA[7:0], exIn.instruction[7:0]};
         default:           aluB = opB;
      endcase
      // Branches, jumps and BTR pass A straight through the adder
      if (ctrl.brType != execPkg::brNone || ctrl.resultSel == execPkg::resBtr) begin
         aluB = '0;
      end
   end

   execAlu i_execAlu (
      .inA      (opA),
      .inB      (aluB),
      .ctrl     (ctrl),
      .out      (aluOut),
      .carryOut (carryOut),
      .flags    (flags)
   );

   execResolve i_execResolve (
      .ctrl        (ctrl),
      .aluOut      (aluOut),
      .carryOut    (carryOut),
      .flags       (flags),
      .opA         (opA),
      .incrPC      (exIn.incrPC),
      .instruction (exIn.instruction),
      .result      (nextOut.result),
      .newPC       (nextOut.newPC),
      .pcSrc       (nextOut.pcSrc)
   );

   assign nextOut.instruction = exIn.instruction;
   assign nextOut.storeData   = opB;
   assign nextOut.regWrt      = exIn.regWrt;

   ////////////////////
   // EX/MEM register
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         resultValid <= 1'b0;
         exOut       <= '0;
      end else begin
         resultValid <= instValid;
         // Hold the last result between strobes
         if (instValid) begin
            exOut <= nextOut;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/execResolve.sv
/*
   Execute result and branch resolution
   Compare results, bit reversal, branch condition and next PC
*/
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module execResolve (
   input  wire execPkg::ctrl_t     ctrl,
   input  wire execPkg::word_t     aluOut,
   input  wire                     carryOut,
   input  wire execPkg::aluFlags_t flags,
   input  wire execPkg::word_t     opA,
   input  wire execPkg::word_t     incrPC,
   input  wire execPkg::word_t     instruction,
   output execPkg::word_t          result,
   output execPkg::word_t          newPC,
   output logic                    pcSrc
);

   execPkg::word_t imm8;
   execPkg::word_t imm11;
   execPkg::word_t reversed;
   logic           lessThan;
   logic           taken;

   // Signed less-than, corrected for overflow of A - B
   assign lessThan = flags.sign ^ flags.overflow;

   always_comb begin
      for (int i = 0; i < `EXEC_WORD_W; i++) begin
         reversed[i] = aluOut[`EXEC_WORD_W-1-i];
      end
   end

   always_comb begin
      result = aluOut;
      case (ctrl.resultSel)
         execPkg::resSeq: result = execPkg::word_t'(flags.zero);
         execPkg::resSlt: result = execPkg::word_t'(lessThan);
         execPkg::resSle: result = execPkg::word_t'(lessThan | flags.zero);
         execPkg::resSco: result = execPkg::word_t'(carryOut);
         execPkg::resBtr: result = reversed;
         default:         result = aluOut;
      endcase
   end

   ////////////////////
   // Next PC
   ////////////////////

   // Branch and jump offsets are always sign-extended
   assign imm8  = {{(`EXEC_WORD_W-`EXEC_IMM8_W){instruction[`EXEC_IMM8_W-1]}},
                   instruction[`EXEC_IMM8_W-1:0]};
   assign imm11 = {{(`EXEC_WORD_W-`EXEC_IMM11_W){instruction[`EXEC_IMM11_W-1]}},
                   instruction[`EXEC_IMM11_W-1:0]};

   always_comb begin
      newPC = incrPC;
      // B is zero here so the flags describe A
      case (ctrl.brType)
         execPkg::brBeqz: taken = flags.zero;
         execPkg::brBnez: taken = ~flags.zero;
         execPkg::brBltz: taken = flags.sign;
         execPkg::brBgez: taken = ~flags.sign;
         execPkg::brJ, execPkg::brJr: taken = 1'b1;
         default: taken = 1'b0;
      endcase
      if (taken) begin
         case (ctrl.brType)
            execPkg::brJ:  newPC = incrPC + imm11;
            execPkg::brJr: newPC = opA + imm8;
            default:       newPC = incrPC + imm8;
         endcase
      end
   end

   assign pcSrc = taken;

endmodule

`default_nettype wire

// File: hw/execAlu.sv
/*
   Execute ALU
   Optional input inversion, add with carry-in, xor, and, pass-B, flags
*/
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module execAlu (
   input  wire execPkg::word_t inA,
   input  wire execPkg::word_t inB,
   input  wire execPkg::ctrl_t ctrl,
   output execPkg::word_t      out,
   output logic                carryOut,
   output execPkg::aluFlags_t  flags
);

   execPkg::word_t        opA;
   execPkg::word_t        opB;
   execPkg::word_t        sum;
   logic [`EXEC_WORD_W:0] sumExt;

   // Operand inversion for subtract and and-not
   assign opA = ctrl.invA ? ~inA : inA;
   assign opB = ctrl.invB ? ~inB : inB;

   // One extra bit holds the carry out
   assign sumExt   = {1'b0, opA} + {1'b0, opB} + {{`EXEC_WORD_W{1'b0}}, ctrl.cin};
   assign sum      = sumExt[`EXEC_WORD_W-1:0];
   assign carryOut = sumExt[`EXEC_WORD_W];

   always_comb begin
      case (ctrl.aluOp)
         execPkg::aluXor:   out = opA ^ opB;
         execPkg::aluAnd:   out = opA & opB;
         execPkg::aluPassB: out = opB;
         default:           out = sum;
      endcase
   end

   ////////////////////
   // Adder flags
   ////////////////////

   assign flags.zero = (sum == '0);
   assign flags.sign = sum[`EXEC_WORD_W-1];

   // Same input signs and a flipped result sign
   assign flags.overflow = (opA[`EXEC_WORD_W-1] == opB[`EXEC_WORD_W-1]) &&
                           (sum[`EXEC_WORD_W-1] != opA[`EXEC_WORD_W-1]);

endmodule

`default_nettype wire

// File: hw/execDecode.sv
/*
   Execute control decoder
   Opcode and function bits to ALU, operand B, result and branch controls
*/
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module execDecode (
   input  wire execPkg::word_t instruction,
   output execPkg::ctrl_t      ctrl
);

   // Opcode map of the kept instructions
   localparam execPkg::opcode_t opJ     = 5'b00100;
   localparam execPkg::opcode_t opJr    = 5'b00101;
   localparam execPkg::opcode_t opAddi  = 5'b01000;
   localparam execPkg::opcode_t opSubi  = 5'b01001;
   localparam execPkg::opcode_t opXori  = 5'b01010;
   localparam execPkg::opcode_t opAndni = 5'b01011;
   localparam execPkg::opcode_t opBeqz  = 5'b01100;
   localparam execPkg::opcode_t opBnez  = 5'b01101;
   localparam execPkg::opcode_t opBltz  = 5'b01110;
   localparam execPkg::opcode_t opBgez  = 5'b01111;
   localparam execPkg::opcode_t opSlbi  = 5'b10010;
   localparam execPkg::opcode_t opLbi   = 5'b11000;
   localparam execPkg::opcode_t opBtr   = 5'b11001;
   localparam execPkg::opcode_t opRType = 5'b11011;
   localparam execPkg::opcode_t opSeq   = 5'b11100;
   localparam execPkg::opcode_t opSlt   = 5'b11101;
   localparam execPkg::opcode_t opSle   = 5'b11110;
   localparam execPkg::opcode_t opSco   = 5'b11111;

   execPkg::opcode_t opcode;
   logic [1:0]       funct;

   assign opcode = instruction[`EXEC_OPC_LSB +: `EXEC_OPC_W];
   assign funct  = instruction[1:0];

   always_comb begin
      // Default is a plain register add with no branch
      ctrl           = '0;
      ctrl.aluOp     = execPkg::aluAdd;
      ctrl.bSel      = execPkg::bSelReg;
      ctrl.resultSel = execPkg::resAlu;
      ctrl.brType    = execPkg::brNone;

      case (opcode)
         opRType: begin
            // funct 00 add, 01 sub, 10 xor, 11 andn
            case (funct)
               2'b01: begin
                  ctrl.invA = 1'b1;
                  ctrl.cin  = 1'b1;
               end
               2'b10: ctrl.aluOp = execPkg::aluXor;
               2'b11: begin
                  ctrl.aluOp = execPkg::aluAnd;
                  ctrl.invB  = 1'b1;
               end
               default: ctrl.aluOp = execPkg::aluAdd;
            endcase
         end
         opAddi: ctrl.bSel = execPkg::bSelImm5;
         opSubi: begin
            // B minus A as ~A + B + 1
            ctrl.bSel = execPkg::bSelImm5;
            ctrl.invA = 1'b1;
            ctrl.cin  = 1'b1;
         end
         opXori: begin
            ctrl.aluOp   = execPkg::aluXor;
            ctrl.bSel    = execPkg::bSelImm5;
            ctrl.zeroExt = 1'b1;
         end
         opAndni: begin
            ctrl.aluOp   = execPkg::aluAnd;
            ctrl.bSel    = execPkg::bSelImm5;
            ctrl.invB    = 1'b1;
            ctrl.zeroExt = 1'b1;
         end
         // Compares run A - B through the adder
         opSeq, opSlt, opSle: begin
            ctrl.invB      = 1'b1;
            ctrl.cin       = 1'b1;
            ctrl.resultSel = (opcode == opSeq) ? execPkg::resSeq :
                             (opcode == opSlt) ? execPkg::resSlt : execPkg::resSle;
         end
         opSco:  ctrl.resultSel = execPkg::resSco;
         opBtr:  ctrl.resultSel = execPkg::resBtr;
         opLbi: begin
            ctrl.aluOp = execPkg::aluPassB;
            ctrl.bSel  = execPkg::bSelImm8;
         end
         opSlbi: begin
            ctrl.aluOp = execPkg::aluPassB;
            ctrl.bSel  = execPkg::bSelSlbi;
         end
         opBeqz: ctrl.brType = execPkg::brBeqz;
         opBnez: ctrl.brType = execPkg::brBnez;
         opBltz: ctrl.brType = execPkg::brBltz;
         opBgez: ctrl.brType = execPkg::brBgez;
         opJ:    ctrl.brType = execPkg::brJ;
         opJr:   ctrl.brType = execPkg::brJr;
         default: ctrl.aluOp = execPkg::aluAdd;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/execPkg.sv
/*
   Shared types of the execute stage
   Word, opcode and forwarding typedefs, control encodings, stage structs
*/
`default_nettype none
`include "exec_params.svh"

package execPkg;

   typedef logic [`EXEC_WORD_W-1:0] word_t;
   typedef logic [`EXEC_OPC_W-1:0]  opcode_t;
   typedef logic [1:0]              fwdSel_t;
   typedef logic [2:0]              aluOp_t;
   typedef logic [2:0]              resultSel_t;
   typedef logic [2:0]              brType_t;

   // Forwarding sources
   localparam fwdSel_t fwdRegFile = 2'd0;
   localparam fwdSel_t fwdWb      = 2'd1;
   localparam fwdSel_t fwdEx      = 2'd2;

   // ALU operations
   localparam aluOp_t aluAdd   = 3'd0;
   localparam aluOp_t aluXor   = 3'd1;
   localparam aluOp_t aluAnd   = 3'd2;
   localparam aluOp_t aluPassB = 3'd3;

   // Operand B sources
   localparam logic [1:0] bSelReg  = 2'd0;
   localparam logic [1:0] bSelImm5 = 2'd1;
   localparam logic [1:0] bSelImm8 = 2'd2;
   localparam logic [1:0] bSelSlbi = 2'd3;

   // Result selection
   localparam resultSel_t resAlu = 3'd0;
   localparam resultSel_t resSeq = 3'd1;
   localparam resultSel_t resSlt = 3'd2;
   localparam resultSel_t resSle = 3'd3;
   localparam resultSel_t resSco = 3'd4;
   localparam resultSel_t resBtr = 3'd5;

   // Branch and jump kinds
   localparam brType_t brNone = 3'd0;
   localparam brType_t brBeqz = 3'd1;
   localparam brType_t brBnez = 3'd2;
   localparam brType_t brBltz = 3'd3;
   localparam brType_t brBgez = 3'd4;
   localparam brType_t brJ    = 3'd5;
   localparam brType_t brJr   = 3'd6;

   typedef struct packed {
      aluOp_t     aluOp;
      logic       invA;
      logic       invB;
      logic       cin;
      logic [1:0] bSel;
      logic       zeroExt;
      resultSel_t resultSel;
      brType_t    brType;
   } ctrl_t;

   typedef struct packed {
      word_t instruction;
      word_t incrPC;
      word_t regA;
      word_t regB;
      logic  regWrt;
   } exIn_t;

   typedef struct packed {
      word_t instruction;
      word_t result;
      word_t newPC;
      logic  pcSrc;
      word_t storeData;
      logic  regWrt;
   } exOut_t;

   typedef struct packed {
      logic zero;
      logic sign;
      logic overflow;
   } aluFlags_t;

endpackage

`default_nettype wire

// File: include/exec_params.svh
/*
   Width parameters of the execute stage
   Data word, opcode field position and opcode width
*/
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Data and PC width
`define EXEC_WORD_W 16

// Opcode sits in the top five bits of the instruction
`define EXEC_OPC_W 5
`define EXEC_OPC_LSB 11

// Immediate field widths used for extension
`define EXEC_IMM5_W 5
`define EXEC_IMM8_W 8
`define EXEC_IMM11_W 11

`endif
